/* hw/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    // upper nibble of every control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    typedef enum logic [3:0] {
        idle,
        w_start,
        w_ctrl,
        w_addr,
        w_data,
        r_start,
        r_ctrl,
        r_data,
        stop,
        done
    } main_state_e;

    // operations handed from the controller to the line sequencer
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_byte_out,
        op_byte_in
    } link_op_e;

endpackage

/* hw/eeprom_ifs.sv */
`timescale 1ns/10ps

// controller to line sequencer, go/done pulses
interface link_if;
    eeprom_pkg::link_op_e              op;
    logic                              go;
    logic [eeprom_pkg::DATA_W-1:0]     tx_byte;
    logic                              done;
    logic [eeprom_pkg::DATA_W-1:0]     rx_byte;

    modport ctrl (output op, go, tx_byte, input done, rx_byte);
    modport seq  (input op, go, tx_byte, output done, rx_byte);
endinterface

interface scl_if;
    logic run;
    logic scl;
    logic low_mid;  // middle of scl low
    logic high_mid; // middle of scl high

    modport gen  (input run, output scl, low_mid, high_mid);
    modport user (output run, input scl, low_mid, high_mid);
endinterface

interface shift_if;
    logic                              load;
    logic [eeprom_pkg::DATA_W-1:0]     load_byte;
    logic                              shift;
    logic                              sin;
    logic                              msb;
    logic [eeprom_pkg::DATA_W-1:0]     value;
    logic                              last;

    modport user  (output load, load_byte, shift, sin, input msb, value, last);
    modport store (input load, load_byte, shift, sin, output msb, value, last);
endinterface

/* hw/eeprom_ctrl.sv */
`timescale 1ns/10ps

module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    link_if.ctrl                          link
);

    eeprom_pkg::main_state_e state;
    eeprom_pkg::main_state_e nxt_state;
    eeprom_pkg::link_op_e    nxt_op;

    logic                          issue;
    logic                          is_rd;
    logic                          pend;   // op handed out, done not yet seen
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;
    logic [eeprom_pkg::DATA_W-1:0] rx_q;
    logic [eeprom_pkg::DATA_W-1:0] nxt_byte;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_w;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_r;

    // device code, block bits a10..a8, r/w
    assign ctrl_w = {eeprom_pkg::DEV_TYPE, addr_q[eeprom_pkg::ADDR_W-1 -: 3], 1'b0};
    assign ctrl_r = {eeprom_pkg::DEV_TYPE, addr_q[eeprom_pkg::ADDR_W-1 -: 3], 1'b1};

    assign ack = (state == eeprom_pkg::done);

    always_comb begin
        issue     = 1'b0;
        nxt_state = state;
        nxt_op    = eeprom_pkg::op_start;
        nxt_byte  = ctrl_w;
        case (state)
            eeprom_pkg::idle: if (wr || rd) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::w_start;
            end
            eeprom_pkg::w_start: if (link.done) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::w_ctrl;
                nxt_op    = eeprom_pkg::op_byte_out;
            end
            eeprom_pkg::w_ctrl: if (link.done) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::w_addr;
                nxt_op    = eeprom_pkg::op_byte_out;
                nxt_byte  = addr_q[7:0];
            end
            eeprom_pkg::w_addr: if (link.done) begin
                issue = 1'b1;
                if (is_rd) begin
                    nxt_state = eeprom_pkg::r_start;  // repeated start
                end else begin
                    nxt_state = eeprom_pkg::w_data;
                    nxt_op    = eeprom_pkg::op_byte_out;
                    nxt_byte  = wdata_q;
                end
            end
            eeprom_pkg::r_start: if (link.done) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::r_ctrl;
                nxt_op    = eeprom_pkg::op_byte_out;
                nxt_byte  = ctrl_r;
            end
            eeprom_pkg::r_ctrl: if (link.done) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::r_data;
                nxt_op    = eeprom_pkg::op_byte_in;
            end
            eeprom_pkg::w_data, eeprom_pkg::r_data: if (link.done) begin
                issue     = 1'b1;
                nxt_state = eeprom_pkg::stop;
                nxt_op    = eeprom_pkg::op_stop;
            end
            eeprom_pkg::stop: if (link.done) nxt_state = eeprom_pkg::done;
            default: nxt_state = eeprom_pkg::idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= eeprom_pkg::idle;
            link.go <= 1'b0;
            is_rd   <= 1'b0;
            pend    <= 1'b0;
        end else begin
            state   <= nxt_state;
            link.go <= issue;
            pend    <= link.go | (pend & ~link.done);
            if (state == eeprom_pkg::idle && (wr || rd))
                is_rd <= !wr;   // wr wins
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            link.op      <= nxt_op;
            link.tx_byte <= nxt_byte;
        end
        if (state == eeprom_pkg::idle && (wr || rd)) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == eeprom_pkg::r_data && link.done)
            rx_q <= link.rx_byte;
        if (state == eeprom_pkg::stop && link.done && is_rd)
            rdata <= rx_q;
    end

    a_go_idle: assert property (@(posedge CLK) disable iff (RESET) link.go |-> !pend);
    a_ack_one: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack);

endmodule

/* hw/bit_clock.sv */
`timescale 1ns/10ps

module bit_clock #(
    parameter int SCL_HALF = 4
) (
    input  logic CLK,
    input  logic RESET,
    scl_if.gen   clk
);

    localparam int CNT_W = $clog2(SCL_HALF);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(SCL_HALF / 2);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SCL_HALF - 1);

    logic [CNT_W-1:0] cnt;  // counts down through each half period

    always_ff @(posedge CLK) begin
        if (RESET || !clk.run) begin
            cnt     <= '0;
            clk.scl <= 1'b1;  // bus idle level
        end else if (cnt == '0) begin
            cnt     <= LAST;
            clk.scl <= ~clk.scl;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // mid strobes sit early enough that a registered sda update lands before the next edge
    assign clk.low_mid  = clk.run && !clk.scl && (cnt == MID);
    assign clk.high_mid = clk.run && clk.scl && (cnt == MID);

    a_low_mid: assert property (@(posedge CLK) disable iff (RESET)
        clk.low_mid |=> !clk.scl);

endmodule

/* hw/line_seq.sv */
`timescale 1ns/10ps

module line_seq (
    input  logic  CLK,
    input  logic  RESET,
    link_if.seq   link,
    scl_if.user   clk,
    shift_if.user sh,
    output logic  sda_out,
    output logic  sda_oe,
    input  logic  sda_in
);

    typedef enum logic [2:0] {s_idle, s_start, s_stop, s_out, s_in} seq_state_e;

    seq_state_e state;
    logic       armed;  // low phase of current scl period handled
    logic       nine;   // ack / nack clock
    logic       sda_lvl;

    assign sh.load      = link.go && (link.op == eeprom_pkg::op_byte_out ||
                                      link.op == eeprom_pkg::op_byte_in);
    assign sh.load_byte = (link.op == eeprom_pkg::op_byte_out) ? link.tx_byte : '0;
    assign sh.sin       = sda_in;
    assign sh.shift     = (state == s_out || state == s_in) && clk.high_mid && armed && !nine;
    assign link.rx_byte = sh.value;

    assign sda_lvl = !(sda_oe && !sda_out);

    // every op finishes at a high_mid, so the next go is in before the next low_mid
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= s_idle;
            armed     <= 1'b0;
            nine      <= 1'b0;
            clk.run   <= 1'b0;
            sda_oe    <= 1'b0;
            sda_out   <= 1'b1;
            link.done <= 1'b0;
        end else begin
            link.done <= 1'b0;
            case (state)
                s_idle: if (link.go) begin
                    armed   <= 1'b0;
                    nine    <= 1'b0;
                    clk.run <= 1'b1;
                    case (link.op)
                        eeprom_pkg::op_start:    state <= s_start;
                        eeprom_pkg::op_stop:     state <= s_stop;
                        eeprom_pkg::op_byte_out: state <= s_out;
                        eeprom_pkg::op_byte_in:  state <= s_in;
                    endcase
                end
                s_start: if (clk.low_mid) begin
                    sda_oe <= 1'b0;
                    armed  <= 1'b1;
                end else if (clk.high_mid && armed) begin
                    sda_oe    <= 1'b1;  // sda falls with scl high
                    sda_out   <= 1'b0;
                    link.done <= 1'b1;
                    state     <= s_idle;
                end
                s_stop: if (clk.low_mid) begin
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b0;
                    armed   <= 1'b1;
                end else if (clk.high_mid && armed) begin
                    sda_oe    <= 1'b0;
                    clk.run   <= 1'b0;
                    link.done <= 1'b1;
                    state     <= s_idle;
                end
                s_out, s_in: if (clk.low_mid) begin
                    armed   <= 1'b1;
                    nine    <= sh.last;
                    sda_out <= (state == s_out) ? sh.msb : 1'b1;
                    // released for slave ack, driven high as master nack
                    sda_oe  <= (state == s_out) ? !sh.last : sh.last;
                end else if (clk.high_mid && armed) begin
                    armed <= 1'b0;
                    if (nine) begin
                        link.done <= 1'b1;
                        state     <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        clk.scl && $changed(sda_lvl) |-> link.done);

endmodule

/* hw/byte_shift.sv */
`timescale 1ns/10ps

module byte_shift (
    input  logic   CLK,
    input  logic   RESET,
    shift_if.store sh
);

    logic [eeprom_pkg::DATA_W-1:0] sr;
    logic [3:0]                    cnt;  // bits moved since load

    always_ff @(posedge CLK) begin
        if (RESET)
            cnt <= '0;
        else if (sh.load)
            cnt <= '0;
        else if (sh.shift)
            cnt <= cnt + 1'b1;
    end

    // msb first out, new bit in at the bottom
    always_ff @(posedge CLK) begin
        if (sh.load)
            sr <= sh.load_byte;
        else if (sh.shift)
            sr <= {sr[eeprom_pkg::DATA_W-2:0], sh.sin};
    end

    assign sh.msb   = sr[eeprom_pkg::DATA_W-1];
    assign sh.value = sr;
    assign sh.last  = (cnt == 4'(eeprom_pkg::DATA_W));

endmodule

/* hw/eeprom_wr.sv */
`timescale 1ns/10ps

module eeprom_wr #(
    parameter int SCL_HALF = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wdata,
    output logic                          ack,
    output logic [eeprom_pkg::DATA_W-1:0] rdata,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe,
    input  logic                          sda_in
);

    link_if  link_i ();
    scl_if   scl_i ();
    shift_if shift_i ();

    eeprom_ctrl ctrl_i (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .link  (link_i.ctrl)
    );

    bit_clock #(.SCL_HALF(SCL_HALF)) bit_clock_i (
        .CLK   (CLK),
        .RESET (RESET),
        .clk   (scl_i.gen)
    );

    line_seq line_seq_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .link    (link_i.seq),
        .clk     (scl_i.user),
        .sh      (shift_i.user),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

    byte_shift byte_shift_i (
        .CLK   (CLK),
        .RESET (RESET),
        .sh    (shift_i.store)
    );

    assign scl = scl_i.scl;

endmodule

/* verification/eeprom_slave_model.sv */
`timescale 1ns/10ps

// two-wire EEPROM slave, bus sampled on the system clock
module eeprom_slave_model (
    input  logic       CLK,
    input  logic       scl,
    input  logic       sda,
    output logic       sda_low,
    output int         errors,
    output logic [7:0] blocks_seen
);

    typedef enum logic [2:0] {ph_idle, ph_ctrl, ph_addr, ph_wdata, ph_rdata, ph_end} phase_e;

    logic [7:0]  mem [0:2047];
    phase_e      phase;
    logic        scl_q;
    logic        sda_q;
    logic        in_frame;  // start seen, no stop yet
    logic        rep;       // frame opened by a repeated start
    logic        ack_now;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [2:0]  blk;
    logic [10:0] ptr;
    int          cnt;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[11'(i)] = 8'h00;
        phase       = ph_idle;
        scl_q       = 1'b1;
        sda_q       = 1'b1;
        in_frame    = 1'b0;
        rep         = 1'b0;
        ack_now     = 1'b0;
        cnt         = 0;
        sda_low     = 1'b0;
        errors      = 0;
        blocks_seen = 8'h00;
    end

    task automatic decode_byte();
        ack_now = 1'b1;
        case (phase)
            ph_ctrl: begin
                if (shreg[7:4] != eeprom_pkg::DEV_TYPE) begin
                    $display("slave: control byte %02h at %0t lacks device type 1010", shreg, $time);
                    errors++;
                    ack_now = 1'b0;
                    phase   = ph_end;
                end else begin
                    if (shreg[0] != rep) begin
                        $display("slave: control byte %02h at %0t has the wrong r/w bit", shreg, $time);
                        errors++;
                    end
                    if (rep && shreg[3:1] != blk) begin
                        $display("slave: block bits changed across repeated start at %0t", $time);
                        errors++;
                    end
                    blk              = shreg[3:1];
                    blocks_seen[blk] = 1'b1;
                    tx               = mem[ptr];
                    phase            = shreg[0] ? ph_rdata : ph_addr;
                end
            end
            ph_addr: begin
                ptr   = {blk, shreg};
                phase = ph_wdata;
            end
            ph_wdata: begin
                mem[ptr] = shreg;
                phase    = ph_end;
            end
            default: ack_now = 1'b0;  // read byte, master answers
        endcase
    endtask

    always @(posedge CLK) begin
        if (scl_q && scl && sda_q && !sda) begin
            rep      = in_frame;  // start
            in_frame = 1'b1;
            phase    = ph_ctrl;
            cnt      = 0;
        end else if (scl_q && scl && !sda_q && sda) begin
            in_frame = 1'b0;      // stop
            phase    = ph_idle;
        end else if (!scl_q && scl && phase != ph_idle) begin
            if (cnt == 8) begin
                cnt = 0;
                if (phase == ph_rdata && !ack_now) begin
                    if (!sda) begin
                        $display("slave: master acknowledged the read byte at %0t", $time);
                        errors++;
                    end
                    phase = ph_end;
                end
            end else if (phase != ph_end) begin
                shreg = {shreg[6:0], sda};
                cnt++;
                if (cnt == 8)
                    decode_byte();
            end
        end else if (scl_q && !scl) begin
            if (cnt == 8)
                sda_low <= ack_now;
            else if (phase == ph_rdata)
                sda_low <= !tx[3'(7 - cnt)];
            else
                sda_low <= 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* verification/eeprom_wr_tb.sv */
`timescale 1ns/10ps

module eeprom_wr_tb;

    localparam int LIMIT = 3000;  // cycles allowed per transaction

    logic                          CLK;
    logic                          RESET;
    logic                          wr;
    logic                          rd;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    logic                          ack;
    logic [eeprom_pkg::DATA_W-1:0] rdata;
    logic                          scl;
    logic                          sda_out;
    logic                          sda_oe;
    logic                          sda_low;
    logic                          sda;
    logic [7:0]                    blocks_seen;
    int                            slave_errs;
    int                            value_errs = 0;
    int                            other_errs = 0;
    int                            acks = 0;
    int                            cmds = 0;
    logic [eeprom_pkg::DATA_W-1:0] ref_mem [0:2047];
    logic [eeprom_pkg::ADDR_W-1:0] written [$];

    // open drain line that either side can pull low
    assign sda = !((sda_oe && !sda_out) || sda_low);

    eeprom_wr #(.SCL_HALF(4)) eeprom_wr_i (
        .CLK, .RESET, .wr, .rd, .addr, .wdata, .ack, .rdata,
        .scl, .sda_out, .sda_oe, .sda_in(sda)
    );

    eeprom_slave_model slave_i (
        .CLK, .scl, .sda, .sda_low, .errors(slave_errs), .blocks_seen
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        if (!RESET && ack)
            acks++;
    end

    task automatic check_byte(input string name, input logic [eeprom_pkg::DATA_W-1:0] got,
                              input logic [eeprom_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    // one command plus stray strobes while it runs if noisy
    task automatic run_cmd(input logic is_wr, input logic [eeprom_pkg::ADDR_W-1:0] a,
                           input logic [eeprom_pkg::DATA_W-1:0] d, input logic noisy,
                           output logic [eeprom_pkg::DATA_W-1:0] got);
        int   n;
        int   kind;
        logic seen;
        logic stray;
        n     = 0;
        seen  = 1'b0;
        cmds++;
        wr    <= is_wr;
        rd    <= !is_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        while (!seen && n < LIMIT) begin
            stray = noisy && ($urandom_range(0, 7) == 0);
            kind  = $urandom_range(0, 2);  // wr alone, rd alone or both
            wr    <= stray && kind != 1;
            rd    <= stray && kind != 0;
            addr  <= eeprom_pkg::ADDR_W'($urandom);
            wdata <= eeprom_pkg::DATA_W'($urandom);
            @(posedge CLK);
            seen = ack;
            n++;
        end
        wr  <= 1'b0;
        rd  <= 1'b0;
        got = rdata;
        if (!seen) begin
            $display("timeout: no ack within %0d cycles of command %0d", LIMIT, cmds);
            other_errs++;
        end else begin
            @(posedge CLK);
            check_bit("ack", ack, 1'b0);  // single cycle pulse
        end
    endtask

    initial begin
        logic [eeprom_pkg::ADDR_W-1:0] a;
        logic [eeprom_pkg::DATA_W-1:0] d;
        logic [eeprom_pkg::DATA_W-1:0] got;
        logic                          is_wr;
        void'($urandom(32'hef0b));
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < 2048; i++)
            ref_mem[11'(i)] = '0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check_bit("ack", ack, 1'b0);
        check_bit("sda_oe", sda_oe, 1'b0);
        check_bit("scl", scl, 1'b1);

        // write and read back once in every address block
        for (int b = 0; b < 8 && other_errs == 0; b++) begin
            a = {3'(b), 8'($urandom)};
            d = 8'($urandom);
            run_cmd(1'b1, a, d, 1'b0, got);
            ref_mem[a] = d;
            written.push_back(a);
            run_cmd(1'b0, a, 8'h00, 1'b0, got);
            check_byte("rdata", got, ref_mem[a]);
        end

        for (int i = 0; i < 200 && other_errs == 0; i++) begin
            is_wr = 1'($urandom_range(0, 1));
            a     = eeprom_pkg::ADDR_W'($urandom);
            if (!is_wr && $urandom_range(0, 1) == 1)
                a = written[$urandom_range(0, written.size() - 1)];
            d = 8'($urandom);
            run_cmd(is_wr, a, d, $urandom_range(0, 2) == 0, got);
            if (is_wr) begin
                ref_mem[a] = d;
                written.push_back(a);
            end else begin
                check_byte("rdata", got, ref_mem[a]);
            end
        end

        repeat (600) @(posedge CLK);  // long enough for an accepted stray command to ack
        if (acks != cmds) begin
            $display("saw %0d acks for %0d commands", acks, cmds);
            other_errs++;
        end
        if (blocks_seen != 8'hff) begin
            $display("address blocks seen on the bus %08b, not all eight", blocks_seen);
            other_errs++;
        end
        $display("errors: value %0d, slave %0d, other %0d", value_errs, slave_errs, other_errs);
        if (value_errs + slave_errs + other_errs == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* eeprom_wr.f */
hw/eeprom_pkg.sv
hw/eeprom_ifs.sv
hw/eeprom_ctrl.sv
hw/bit_clock.sv
hw/line_seq.sv
hw/byte_shift.sv
hw/eeprom_wr.sv
verification/eeprom_slave_model.sv
verification/eeprom_wr_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module eeprom_wr_tb \
    -f eeprom_wr.f -o eeprom_wr_sim || exit 1
out=$(./obj_dir/eeprom_wr_sim)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
